//--- vlog.f
source/itm_cfg_pkg.sv
source/itm_trace_pkg.sv
source/itm_delay_sr.sv
source/itm_conf_regs.sv
source/itm_trace_qualificator.sv
source/itm_trace_emitter.sv
source/itm_top.sv
testbench/tb_itm_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the trace unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_itm_top -f vlog.f --Mdir obj_dir -o tb_itm_top

sim_output="$(./obj_dir/tb_itm_top 2>&1 || true)"
echo "$sim_output"

if grep -qx "PASS: all tests" <<< "$sim_output"; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

//--- testbench/tb_itm_top.sv
// testbench for itm_top with stimulus table, reference model, check task and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_itm_top;

   import itm_cfg_pkg::*;
   import itm_trace_pkg::*;

   // one table row per clock cycle
   typedef struct packed {
      logic                       wr;
      logic [conf_addr_width-1:0] addr;
      logic [conf_data_width-1:0] wdata;
      logic                       valid;
      logic [pc_width-1:0]        pc;
      logic [timestamp_width-1:0] ts;
      logic                       trig;
      // table carries a known trigger_out for this row
      logic                       known;
      logic                       exp_trig;
   } stim_t;

   // model view of a sample inside the delay line
   typedef struct packed {
      itm_sample_t smp;
      logic        match;
   } hist_t;

   // expected message output for one cycle
   typedef struct packed {
      logic     valid;
      itm_msg_t msg;
   } exp_t;

   logic                       clk;
   logic                       arst_n;
   itm_sample_t                sample_in;
   logic                       trigger_in;
   logic                       reg_wr;
   logic [conf_addr_width-1:0] reg_addr;
   logic [conf_data_width-1:0] reg_wdata;
   logic [conf_data_width-1:0] reg_rdata;
   logic                       trigger_out;
   logic                       msg_valid;
   itm_msg_t                   msg;

   stim_t                      rows [$];
   hist_t                      hist_q [$];
   exp_t                       exp_q [$];
   // register contents as software wrote them
   logic [conf_data_width-1:0] mdl_regs [8];
   logic                       gap_pending;
   logic [timestamp_width-1:0] ts_count;
   integer                     seed;
   int                         err_count;
   int                         limit_cycles;
   bit                         table_built;

   itm_top i_dut (
      .clk         (clk),
      .arst_n      (arst_n),
      .sample_in   (sample_in),
      .trigger_in  (trigger_in),
      .reg_wr      (reg_wr),
      .reg_addr    (reg_addr),
      .reg_wdata   (reg_wdata),
      .reg_rdata   (reg_rdata),
      .trigger_out (trigger_out),
      .msg_valid   (msg_valid),
      .msg         (msg)
   );

   // 100 ns period
   initial clk = 1'b0;
   always #50 clk = ~clk;

   task automatic stop_run(input string reason);
      $display("%s", reason);
      $display("FAIL: see errors above");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected) begin
         err_count = err_count + 1;
         stop_run($sformatf("FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
                            $time, name, actual, expected));
      end
   endtask

   // table builders
   task automatic append_write(input logic [conf_addr_width-1:0] addr,
                               input logic [conf_data_width-1:0] data);
      stim_t r;
      r       = '0;
      r.wr    = 1'b1;
      r.addr  = addr;
      r.wdata = data;
      r.known = 1'b1;
      rows.push_back(r);
   endtask

   task automatic queue_read(input logic [conf_addr_width-1:0] addr);
      stim_t r;
      r       = '0;
      r.addr  = addr;
      r.known = 1'b1;
      rows.push_back(r);
   endtask

   task automatic put_sample(input logic valid, input logic [pc_width-1:0] pc,
                             input logic trig, input logic known, input logic exp_trig);
      stim_t r;
      r          = '0;
      r.valid    = valid;
      r.pc       = pc;
      r.ts       = ts_count;
      r.trig     = trig;
      r.known    = known;
      r.exp_trig = exp_trig;
      rows.push_back(r);
      ts_count = ts_count + 16'd3;
   endtask

   // both bounds in four halves, high word first
   task automatic window_rows(input logic [31:0] lo, input logic [31:0] hi);
      append_write(reg_pc_lower_hi, lo[31:16]);
      append_write(reg_pc_lower_lo, lo[15:0]);
      append_write(reg_pc_upper_hi, hi[31:16]);
      append_write(reg_pc_upper_lo, hi[15:0]);
   endtask

   function automatic logic [conf_data_width-1:0] expected_rdata(
      input logic [conf_addr_width-1:0] addr);
      // id word is constant, unwritten words stay zero
      if (addr == 3'd0) begin
         return itm_id_value;
      end else begin
         return mdl_regs[addr];
      end
   endfunction

   task automatic build_table();
      logic [31:0] rnd;
      logic [31:0] base;
      // id and zero read-back after reset
      for (int a = 0; a < 8; a++) begin
         queue_read(3'(a));
      end
      // zero window, nothing matches
      put_sample(1'b1, 32'h0000_1000, 1'b0, 1'b1, 1'b0);
      put_sample(1'b1, 32'h0000_0000, 1'b0, 1'b1, 1'b0);
      put_sample(1'b1, 32'h0000_2345, 1'b0, 1'b1, 1'b0);
      // trigger_in four cycles later captures 0x2345 with gap set
      put_sample(1'b0, 32'h0, 1'b0, 1'b1, 1'b0);
      put_sample(1'b0, 32'h0, 1'b0, 1'b1, 1'b0);
      put_sample(1'b0, 32'h0, 1'b0, 1'b1, 1'b0);
      put_sample(1'b0, 32'h0, 1'b1, 1'b1, 1'b0);
      // window 0x1000 to 0x1fff, then read back
      window_rows(32'h0000_1000, 32'h0000_1fff);
      for (int a = 2; a < 6; a++) begin
         queue_read(3'(a));
      end
      // bounds, one below, one above
      put_sample(1'b1, 32'h0000_1000, 1'b0, 1'b1, 1'b1);
      put_sample(1'b1, 32'h0000_1fff, 1'b0, 1'b1, 1'b1);
      put_sample(1'b1, 32'h0000_0fff, 1'b0, 1'b1, 1'b0);
      put_sample(1'b1, 32'h0000_2000, 1'b0, 1'b1, 1'b0);
      // back-to-back matches
      put_sample(1'b1, 32'h0000_1100, 1'b0, 1'b1, 1'b1);
      put_sample(1'b1, 32'h0000_1104, 1'b0, 1'b1, 1'b1);
      put_sample(1'b1, 32'h0000_1108, 1'b0, 1'b1, 1'b1);
      // invalid samples between matches keep gap clear
      put_sample(1'b0, 32'h0000_1200, 1'b0, 1'b1, 1'b0);
      put_sample(1'b0, 32'h0000_1204, 1'b0, 1'b1, 1'b0);
      put_sample(1'b1, 32'h0000_1208, 1'b0, 1'b1, 1'b1);
      // one dropped valid sample sets gap
      put_sample(1'b1, 32'h0000_3000, 1'b0, 1'b1, 1'b0);
      put_sample(1'b1, 32'h0000_120c, 1'b0, 1'b1, 1'b1);
      // pre-trigger capture of a non-matching sample
      put_sample(1'b1, 32'h0000_8000, 1'b0, 1'b1, 1'b0);
      put_sample(1'b0, 32'h0, 1'b0, 1'b1, 1'b0);
      put_sample(1'b0, 32'h0, 1'b0, 1'b1, 1'b0);
      put_sample(1'b0, 32'h0, 1'b0, 1'b1, 1'b0);
      put_sample(1'b0, 32'h0, 1'b1, 1'b1, 1'b0);
      // random windows and samples around them
      for (int w = 0; w < 3; w++) begin
         rnd  = $random(seed);
         base = {16'h0000, rnd[15:8], 8'h00} + 32'h100;
         window_rows(base, base + 32'h3f);
         for (int s = 0; s < 16; s++) begin
            rnd = $random(seed);
            put_sample(rnd[1:0] != 2'b00, base - 32'h10 + {25'd0, rnd[14:8]},
                       rnd[6:4] == 3'b000, 1'b0, 1'b0);
         end
      end
      // flush the delay line
      for (int i = 0; i < 8; i++) begin
         put_sample(1'b0, 32'h0, 1'b0, 1'b1, 1'b0);
      end
   endtask

   // one cycle of the reference model, called mid-cycle
   task automatic model_step(input stim_t r);
      logic [31:0] lo;
      logic [31:0] hi;
      logic        match;
      hist_t       entry;
      hist_t       old;
      exp_t        due;
      exp_t        nxt;
      lo = {mdl_regs[2], mdl_regs[3]};
      hi = {mdl_regs[4], mdl_regs[5]};
      check_value("reg_rdata", 64'(reg_rdata), 64'(expected_rdata(r.addr)));
      // inclusive window, zero window disables
      match = r.valid && !(lo == 32'd0 && hi == 32'd0) && (r.pc >= lo) && (r.pc <= hi);
      check_value("trigger_out", 64'(trigger_out), 64'(match));
      if (r.known) begin
         check_value("trigger_out (table)", 64'(trigger_out), 64'(r.exp_trig));
      end
      // message decided in the previous cycle
      due = exp_q.pop_front();
      check_value("msg_valid", 64'(msg_valid), 64'(due.valid));
      if (due.valid) begin
         check_value("msg.gap", 64'(msg.gap), 64'(due.msg.gap));
         check_value("msg.timestamp", 64'(msg.timestamp), 64'(due.msg.timestamp));
         check_value("msg.pc", 64'(msg.pc), 64'(due.msg.pc));
      end
      entry.smp.valid     = r.valid;
      entry.smp.timestamp = r.ts;
      entry.smp.pc        = r.pc;
      entry.match         = match;
      hist_q.push_back(entry);
      // sample from four cycles ago meets this cycle's trigger_in
      old = hist_q.pop_front();
      nxt = '0;
      if (old.smp.valid) begin
         if (old.match || r.trig) begin
            nxt.valid         = 1'b1;
            nxt.msg.gap       = gap_pending;
            nxt.msg.timestamp = old.smp.timestamp;
            nxt.msg.pc        = old.smp.pc;
            gap_pending       = 1'b0;
         end else begin
            gap_pending = 1'b1;
         end
      end
      exp_q.push_back(nxt);
      // write lands after this cycle
      if (r.wr && r.addr >= 3'd2 && r.addr <= 3'd5) begin
         mdl_regs[r.addr] = r.wdata;
      end
   endtask

   // watchdog
   initial begin
      wait (table_built);
      repeat (limit_cycles) @(posedge clk);
      stop_run($sformatf("timeout: run did not finish within %0d cycles", limit_cycles));
   end

   initial begin
      arst_n      = 1'b0;
      sample_in   = '0;
      trigger_in  = 1'b0;
      reg_wr      = 1'b0;
      reg_addr    = '0;
      reg_wdata   = '0;
      seed        = 26023;
      err_count   = 0;
      ts_count    = 16'h0010;
      gap_pending = 1'b1;
      for (int i = 0; i < 8; i++) begin
         mdl_regs[i] = '0;
      end
      // delay line starts with invalid samples
      for (int i = 0; i < trace_delay; i++) begin
         hist_q.push_back('0);
      end
      exp_q.push_back('0);
      build_table();
      limit_cycles = rows.size() + 4 + 20;
      table_built  = 1'b1;
      repeat (4) @(posedge clk);
      arst_n <= 1'b1;
      foreach (rows[i]) begin
         @(posedge clk);
         reg_wr              <= rows[i].wr;
         reg_addr            <= rows[i].addr;
         reg_wdata           <= rows[i].wdata;
         sample_in.valid     <= rows[i].valid;
         sample_in.timestamp <= rows[i].ts;
         sample_in.pc        <= rows[i].pc;
         trigger_in          <= rows[i].trig;
         @(negedge clk);
         model_step(rows[i]);
      end
      if (err_count == 0) begin
         $display("PASS: all tests");
         $finish;
      end else begin
         stop_run("errors were found during the run");
      end
   end

endmodule : tb_itm_top

`default_nettype wire

//--- source/itm_top.sv
// instruction trace unit top level with registers, delay line, qualificator, emitter
`timescale 1ns/1ps
`default_nettype none

module itm_top (
   input  logic                                     clk,
   input  logic                                     arst_n,
   input  itm_trace_pkg::itm_sample_t               sample_in,
   input  logic                                     trigger_in,
   input  logic                                     reg_wr,
   input  logic [itm_cfg_pkg::conf_addr_width-1:0]  reg_addr,
   input  logic [itm_cfg_pkg::conf_data_width-1:0]  reg_wdata,
   output logic [itm_cfg_pkg::conf_data_width-1:0]  reg_rdata,
   output logic                                     trigger_out,
   output logic                                     msg_valid,
   output itm_trace_pkg::itm_msg_t                  msg
);

   import itm_cfg_pkg::*;
   import itm_trace_pkg::*;

   // decoded window
   itm_conf_t   conf;
   // sample as seen trace_delay cycles later
   itm_sample_t sample_dly;
   // delayed match or external trigger
   logic        trace_enable;

   // register bank
   itm_conf_regs i_conf_regs (
      .clk       (clk),
      .arst_n    (arst_n),
      .reg_wr    (reg_wr),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .reg_rdata (reg_rdata),
      .conf      (conf)
   );

   // sample history for pre-trigger capture
   itm_delay_sr #(
      .DATA_WIDTH (sample_width)
   ) i_sample_dly (
      .clk    (clk),
      .arst_n (arst_n),
      .din    (sample_in),
      .dout   (sample_dly)
   );

   // window compare and trigger merge
   itm_trace_qualificator i_qualificator (
      .clk          (clk),
      .arst_n       (arst_n),
      .sample_in    (sample_in),
      .conf         (conf),
      .trigger_in   (trigger_in),
      .trigger_out  (trigger_out),
      .trace_enable (trace_enable)
   );

   // message register and gap flag
   itm_trace_emitter i_emitter (
      .clk          (clk),
      .arst_n       (arst_n),
      .sample_dly   (sample_dly),
      .trace_enable (trace_enable),
      .msg_valid    (msg_valid),
      .msg          (msg)
   );

endmodule : itm_top

`default_nettype wire

//--- source/itm_trace_emitter.sv
// registered trace message output with gap flag
`timescale 1ns/1ps
`default_nettype none

module itm_trace_emitter (
   input  logic                       clk,
   input  logic                       arst_n,
   input  itm_trace_pkg::itm_sample_t sample_dly,
   input  logic                       trace_enable,
   output logic                       msg_valid,
   output itm_trace_pkg::itm_msg_t    msg
);

   import itm_trace_pkg::*;

   // this delayed sample becomes a message
   logic emit;
   // valid delayed sample thrown away
   logic drop;
   // some valid sample was lost since the last message
   logic gap_pending_q;

   assign emit = sample_dly.valid && trace_enable;
   assign drop = sample_dly.valid && !trace_enable;

   // message strobe, one cycle per emitted sample
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         msg_valid <= 1'b0;
      end else begin
         msg_valid <= emit;
      end
   end

   // gap bookkeeping
   // starts pending, nothing before reset is known
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         gap_pending_q <= 1'b1;
      end else if (emit) begin
         gap_pending_q <= 1'b0;
      end else if (drop) begin
         gap_pending_q <= 1'b1;
      end
   end

   // payload, only loaded when a message goes out
   always_ff @(posedge clk) begin
      if (emit) begin
         msg.gap       <= gap_pending_q;
         msg.timestamp <= sample_dly.timestamp;
         msg.pc        <= sample_dly.pc;
      end
   end

   // delay line is still flushed right after reset
   a_no_msg_after_reset : assert property (
      @(posedge clk)
      $rose(arst_n) |=> !msg_valid
   ) else $error("itm_trace_emitter: message right after reset");

endmodule : itm_trace_emitter

`default_nettype wire

//--- source/itm_trace_qualificator.sv
// pc window match, match delay and trigger_in combination
`timescale 1ns/1ps
`default_nettype none

module itm_trace_qualificator (
   input  logic                       clk,
   input  logic                       arst_n,
   input  itm_trace_pkg::itm_sample_t sample_in,
   input  itm_cfg_pkg::itm_conf_t     conf,
   input  logic                       trigger_in,
   output logic                       trigger_out,
   output logic                       trace_enable
);

   import itm_trace_pkg::*;
   import itm_cfg_pkg::*;

   // window switched off when both bounds are zero
   logic window_off;
   // undelayed match for the current sample
   logic match;
   // match lined up with sample_dly
   logic match_dly;

   assign window_off = (conf.pc_lower == '0) && (conf.pc_upper == '0);

   // inclusive bounds, only valid samples count
   assign match = sample_in.valid && !window_off &&
                  (sample_in.pc >= conf.pc_lower) &&
                  (sample_in.pc <= conf.pc_upper);

   // trigger goes out in the same cycle
   assign trigger_out = match;

   // same depth as the sample delay line
   itm_delay_sr #(
      .DATA_WIDTH (1)
   ) i_match_dly (
      .clk    (clk),
      .arst_n (arst_n),
      .din    (match),
      .dout   (match_dly)
   );

   // external trigger captures the sample sitting at the delay output
   assign trace_enable = match_dly | trigger_in;

   // no trigger from a bubble, whatever the window holds
   a_trigger_needs_valid : assert property (
      @(posedge clk) disable iff (!arst_n)
      trigger_out |-> sample_in.valid
   ) else $error("itm_trace_qualificator: trigger_out on an invalid sample");

endmodule : itm_trace_qualificator

`default_nettype wire

//--- source/itm_conf_regs.sv
// configuration register bank with write strobe, read-back mux and window decode
`timescale 1ns/1ps
`default_nettype none

module itm_conf_regs (
   input  logic                                      clk,
   input  logic                                      arst_n,
   input  logic                                      reg_wr,
   input  logic [itm_cfg_pkg::conf_addr_width-1:0]   reg_addr,
   input  logic [itm_cfg_pkg::conf_data_width-1:0]   reg_wdata,
   output logic [itm_cfg_pkg::conf_data_width-1:0]   reg_rdata,
   output itm_cfg_pkg::itm_conf_t                    conf
);

   import itm_cfg_pkg::*;

   // window bound halves as written by software
   logic [conf_data_width-1:0] pc_lower_hi_q;
   logic [conf_data_width-1:0] pc_lower_lo_q;
   logic [conf_data_width-1:0] pc_upper_hi_q;
   logic [conf_data_width-1:0] pc_upper_lo_q;

   // address seen as a register name
   itm_reg_e reg_sel;

   assign reg_sel = itm_reg_e'(reg_addr);

   // write port
   // id, reserved and unmapped words drop the write
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc_lower_hi_q <= '0;
         pc_lower_lo_q <= '0;
         pc_upper_hi_q <= '0;
         pc_upper_lo_q <= '0;
      end else if (reg_wr) begin
         case (reg_sel)
            reg_pc_lower_hi: pc_lower_hi_q <= reg_wdata;
            reg_pc_lower_lo: pc_lower_lo_q <= reg_wdata;
            reg_pc_upper_hi: pc_upper_hi_q <= reg_wdata;
            reg_pc_upper_lo: pc_upper_lo_q <= reg_wdata;
            default: ;
         endcase
      end
   end

   // combinational read-back
   always_comb begin
      case (reg_sel)
         reg_id:          reg_rdata = itm_id_value;
         reg_rsvd:        reg_rdata = '0;
         reg_pc_lower_hi: reg_rdata = pc_lower_hi_q;
         reg_pc_lower_lo: reg_rdata = pc_lower_lo_q;
         reg_pc_upper_hi: reg_rdata = pc_upper_hi_q;
         reg_pc_upper_lo: reg_rdata = pc_upper_lo_q;
         // addresses 6 and 7
         default:         reg_rdata = '0;
      endcase
   end

   // high word is the upper half of each bound
   assign conf.pc_lower = {pc_lower_hi_q, pc_lower_lo_q};
   assign conf.pc_upper = {pc_upper_hi_q, pc_upper_lo_q};

   // software only writes inside the register map
   a_wr_addr_in_map : assert property (
      @(posedge clk) disable iff (!arst_n)
      reg_wr |-> (reg_addr < conf_mem_size)
   ) else $error("itm_conf_regs: write to address %0d outside map", reg_addr);

endmodule : itm_conf_regs

`default_nettype wire

//--- source/itm_delay_sr.sv
// fixed-depth shift register used as the trace delay line
`timescale 1ns/1ps
`default_nettype none

module itm_delay_sr #(
   parameter int DATA_WIDTH = 1
) (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic [DATA_WIDTH-1:0] din,
   output logic [DATA_WIDTH-1:0] dout
);

   import itm_trace_pkg::*;

   // stage 0 takes din, last stage feeds dout
   logic [DATA_WIDTH-1:0] stage_q [trace_delay];

   // cleared stages read as invalid samples and zero matches
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < trace_delay; i++) begin
            stage_q[i] <= '0;
         end
      end else begin
         stage_q[0] <= din;
         // advance every other stage by one
         for (int i = 1; i < trace_delay; i++) begin
            stage_q[i] <= stage_q[i-1];
         end
      end
   end

   // din in cycle t shows up here in cycle t+trace_delay
   assign dout = stage_q[trace_delay-1];

endmodule : itm_delay_sr

`default_nettype wire

//--- source/itm_trace_pkg.sv
// trace sample and message structs, field widths and delay depth
`default_nettype none

package itm_trace_pkg;

   // timestamp field width
   localparam int timestamp_width = 16;

   // program counter width
   localparam int pc_width = 32;

   // cycles between a sample and its delayed copy
   // leaves room for a late trigger_in
   localparam int trace_delay = 4;

   // total sample width, valid bit included
   localparam int sample_width = 1 + timestamp_width + pc_width;

   // one retired instruction as reported by the core
   typedef struct packed {
      logic                       valid;
      logic [timestamp_width-1:0] timestamp;
      logic [pc_width-1:0]        pc;
   } itm_sample_t;

   // emitted trace message
   // gap marks lost samples before this one
   typedef struct packed {
      logic                       gap;
      logic [timestamp_width-1:0] timestamp;
      logic [pc_width-1:0]        pc;
   } itm_msg_t;

endpackage : itm_trace_pkg

`default_nettype wire

//--- source/itm_cfg_pkg.sv
// configuration register map, register address enum and decoded window struct
`default_nettype none

package itm_cfg_pkg;

   // number of 16-bit configuration words
   localparam int conf_mem_size = 6;

   // register word width
   localparam int conf_data_width = 16;

   // address bits to reach every register word
   localparam int conf_addr_width = 3;

   // constant returned by the id register
   localparam logic [conf_data_width-1:0] itm_id_value = 16'h4954;

   // register addresses
   typedef enum logic [conf_addr_width-1:0] {
      // read-only id word
      reg_id          = 3'd0,
      // reserved, reads zero
      reg_rsvd        = 3'd1,
      // lower window bound, upper half
      reg_pc_lower_hi = 3'd2,
      // lower window bound, lower half
      reg_pc_lower_lo = 3'd3,
      // upper window bound, upper half
      reg_pc_upper_hi = 3'd4,
      // upper window bound, lower half
      reg_pc_upper_lo = 3'd5
   } itm_reg_e;

   // decoded pc window, both bounds inclusive
   // both zero means matching is off
   typedef struct packed {
      logic [31:0] pc_lower;
      logic [31:0] pc_upper;
   } itm_conf_t;

endpackage : itm_cfg_pkg

`default_nettype wire
